// File: exec_cluster.f
logic/mips_pkg.sv
logic/mips_main_dec.sv
logic/mips_alu_dec.sv
logic/mips_alu.sv
logic/exec_lane.sv
logic/bundle_dispatch.sv
logic/result_collect.sv
logic/exec_cluster.sv
test/exec_cluster_asserts.sv
test/tb_exec_cluster.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -f exec_cluster.f --top-module tb_exec_cluster \
    && ./obj_dir/Vtb_exec_cluster | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

// File: test/tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster;
    import mips_pkg::*;

    localparam int LANES      = 4;
    localparam int WAIT_LIMIT = 100;    // Cycles before a drain gives up

    typedef logic [$clog2(LANES):0] count_t; // Same width as taken_count

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs;
        logic [31:0] rt;
        logic        en;
        logic [31:0] res;               // Expected result
        logic        taken;
        logic        ill;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    slot_t     in_slots [LANES];
    logic      out_valid;
    lane_res_t out_res  [LANES];
    count_t    taken_count;
    logic      any_illegal;

    row_t        rows [$];              // Stimulus and expected values
    int          exp_q [$];             // Bundle numbers in flight
    int          sent_q [$];            // Cycle each in_valid was seen
    int          cyc = 0;
    logic [31:0] rnd;

    exec_cluster #(.LANES(LANES)) DUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_slots(in_slots),
        .out_valid(out_valid), .out_res(out_res), .taken_count(taken_count),
        .any_illegal(any_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] f, input logic [4:0] sh);
        return {6'b000000, 5'd1, 5'd2, 5'd3, sh, f}; // rs=1 rt=2 rd=3
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [15:0] imm);
        return {op, 5'd1, rt, imm};
    endfunction

    // MIPS semantics of the register ops
    function automatic logic [31:0] r_model(input funct_e f, input logic [31:0] s, t);
        case (f)
            F_ADDU:  return s + t;
            F_SUBU:  return s - t;
            F_AND:   return s & t;
            F_OR:    return s | t;
            F_XOR:   return s ^ t;
            F_SLT:   return ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
            F_SLTU:  return (s < t) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] imm_model(input opcode_e op, input logic [31:0] s,
                                              input logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        sx = {{16{imm[15]}}, imm};      // Arithmetic and compare
        zx = {16'h0000, imm};           // Logical ops
        case (op)
            OP_ADDIU: return s + sx;
            OP_SLTI:  return ($signed(s) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_SLTIU: return (s < sx) ? 32'd1 : 32'd0;
            OP_ANDI:  return s & zx;
            OP_ORI:   return s | zx;
            OP_XORI:  return s ^ zx;
            default:  return 32'd0;
        endcase
    endfunction

    task automatic add_row(input logic [31:0] instr, rs, rt, input logic en,
                           input logic [31:0] res, input logic taken, ill);
        rows.push_back(row_t'{instr, rs, rt, en, res, taken, ill});
    endtask

    task automatic build_table();
        funct_e      r_ops [7];
        opcode_e     i_ops [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        r_ops = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT, F_SLTU};
        i_ops = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
        rnd   = 32'h9792_7dd1;
        foreach (r_ops[k]) begin
            rnd = xorshift32(rnd);
            a   = rnd;
            rnd = xorshift32(rnd);
            b   = rnd;
            add_row(rtype(r_ops[k], 5'd0), a, b, 1'b1, r_model(r_ops[k], a, b), 1'b0, 1'b0);
        end
        foreach (i_ops[k]) begin
            rnd = xorshift32(rnd);
            a   = rnd;
            rnd = xorshift32(rnd);
            b   = rnd;                  // rt_val must be ignored
            imm = {1'b1, b[14:0]};      // Negative, so sign and zero extension differ
            add_row(itype(i_ops[k], 5'd2, imm), a, b, 1'b1,
                    imm_model(i_ops[k], a, imm), 1'b0, 1'b0);
        end
        // Constant shifts take shamt, variable shifts rs[4:0]
        add_row(rtype(F_SLL, 5'd4), 32'hFFFF_FFFF, 32'h8000_00F1, 1'b1, 32'h0000_0F10, 0, 0);
        add_row(rtype(F_SRL, 5'd7), 32'hFFFF_FFFF, 32'h8000_00F1, 1'b1, 32'h0100_0001, 0, 0);
        add_row(rtype(F_SRA, 5'd7), 32'hFFFF_FFFF, 32'h8000_00F1, 1'b1, 32'hFF00_0001, 0, 0);
        add_row(rtype(F_SLLV, 5'd9), 32'hFFFF_FFE3, 32'h8000_00F1, 1'b1, 32'h0000_0788, 0, 0);
        add_row(rtype(F_SRLV, 5'd9), 32'h0000_0021, 32'h8000_00F1, 1'b1, 32'h4000_0078, 0, 0);
        add_row(rtype(F_SRAV, 5'd9), 32'h1234_567F, 32'h8000_00F1, 1'b1, 32'hFFFF_FFFF, 0, 0);
        add_row(itype(OP_J, 5'd0, 16'h0100), 32'h0000_0040, 32'd0, 1'b0, 32'd0, 0, 0); // Bubble
        // Branches, two taken per bundle
        add_row(itype(OP_BEQ, 5'd2, 16'h0010), 32'd5, 32'd5, 1'b1, 32'd1, 1, 0);
        add_row(itype(OP_BEQ, 5'd2, 16'h0010), 32'd5, 32'd6, 1'b1, 32'd0, 0, 0);
        add_row(itype(OP_BNE, 5'd2, 16'h0010), 32'd5, 32'd6, 1'b1, 32'd1, 1, 0);
        add_row(itype(OP_BNE, 5'd2, 16'h0010), 32'd7, 32'd7, 1'b1, 32'd0, 0, 0);
        add_row(itype(OP_BLEZ, 5'd0, 16'hFFF0), 32'd0, 32'd9, 1'b1, 32'd1, 1, 0);
        add_row(itype(OP_BLEZ, 5'd0, 16'hFFF0), 32'd3, 32'd9, 1'b1, 32'd0, 0, 0);
        add_row(itype(OP_BGTZ, 5'd0, 16'hFFF0), 32'd3, 32'd9, 1'b1, 32'd1, 1, 0);
        add_row(itype(OP_BGTZ, 5'd0, 16'hFFF0), 32'hFFFF_FFF0, 32'd9, 1'b1, 32'd0, 0, 0);
        add_row(itype(OP_REGIMM, 5'd0, 16'h0004), 32'hFFFF_FFFC, 32'd0, 1'b1, 32'd1, 1, 0);
        add_row(itype(OP_REGIMM, 5'd1, 16'h0004), 32'hFFFF_FFFC, 32'd0, 1'b1, 32'd0, 0, 0);
        add_row(itype(OP_REGIMM, 5'd16, 16'h0004), 32'd7, 32'd0, 1'b1, 32'd0, 0, 0);
        add_row(itype(OP_REGIMM, 5'd17, 16'h0004), 32'd0, 32'd0, 1'b1, 32'd1, 1, 0);
        // Jumps forward rs_val
        add_row(itype(OP_J, 5'd0, 16'h0100), 32'h0040_1000, 32'd1, 1'b1, 32'h0040_1000, 1, 0);
        add_row(itype(OP_JAL, 5'd0, 16'h0200), 32'h0040_2000, 32'd1, 1'b1, 32'h0040_2000, 1, 0);
        add_row(rtype(F_JR, 5'd0), 32'h0000_2468, 32'd1, 1'b1, 32'h0000_2468, 1, 0);
        add_row(rtype(F_MULT, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        add_row(rtype(F_MULTU, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        add_row(rtype(F_DIV, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        add_row(rtype(F_DIVU, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        add_row(rtype(F_MTHI, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        add_row(rtype(F_MTLO, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        add_row(itype(6'h3F, 5'd2, 16'h1234), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1); // Unknown op
        add_row(rtype(6'h3F, 5'd0), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1); // Unknown funct
        add_row(itype(OP_REGIMM, 5'd2, 16'h0004), 32'd6, 32'd7, 1'b1, 32'd0, 0, 1);
        // Disabled slots neither count nor flag
        add_row(itype(OP_J, 5'd0, 16'h0100), 32'h0000_0080, 32'd0, 1'b0, 32'd0, 0, 0);
        add_row(rtype(F_MULT, 5'd0), 32'd6, 32'd7, 1'b0, 32'd0, 0, 0);
        add_row(itype(OP_BEQ, 5'd2, 16'h0010), 32'd5, 32'd5, 1'b0, 32'd0, 0, 0);
        add_row(rtype(F_JR, 5'd0), 32'h0000_1357, 32'd0, 1'b1, 32'h0000_1357, 1, 0);
    endtask

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_res(input lane_res_t got, exp, input int b, lane);
        if (got !== exp) begin
            stop_run($sformatf({"Fail %0t: bundle %0d lane %0d got v%b r%h t%b i%b,",
                                " expected v%b r%h t%b i%b"}, $time, b, lane,
                               got.valid, got.result, got.taken, got.illegal,
                               exp.valid, exp.result, exp.taken, exp.illegal));
        end
    endtask

    task automatic check_summary(input count_t got_cnt, exp_cnt, input logic got_ill,
                                 exp_ill, input int b);
        if (got_cnt !== exp_cnt || got_ill !== exp_ill) begin
            stop_run($sformatf("Fail %0t: bundle %0d summary %0d/%b, expected %0d/%b",
                               $time, b, got_cnt, got_ill, exp_cnt, exp_ill));
        end
    endtask

    task automatic check_bundle();
        int        b;
        int        lat;
        row_t      r;
        lane_res_t exp;
        count_t    cnt;
        logic      ill;
        if (exp_q.size() == 0 || sent_q.size() == 0) begin
            stop_run("out_valid rose while no bundle was in flight");
        end else begin
            b   = exp_q.pop_front();
            lat = cyc - sent_q.pop_front();
            if (lat != 3) begin
                stop_run($sformatf("Fail %0t: bundle %0d latency %0d", $time, b, lat));
            end
            cnt = '0;
            ill = 1'b0;
            for (int i = 0; i < LANES; i++) begin
                r   = rows[LANES*b+i];
                exp = '{valid: r.en, result: r.res, taken: r.taken, illegal: r.ill};
                check_res(out_res[i], exp, b, i);
                if (r.en && r.taken) cnt = cnt + count_t'(1);
                if (r.en && r.ill) ill = 1'b1;
            end
            check_summary(taken_count, cnt, any_illegal, ill, b);
        end
    endtask

    // Outputs sampled mid-cycle, reset drops everything in flight
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            sent_q.delete();
        end else begin
            if (in_valid) sent_q.push_back(cyc);
            if (out_valid) check_bundle();
        end
    end

    task automatic send_bundle(input int b);
        row_t r;
        @(posedge clk);
        in_valid <= 1'b1;
        for (int i = 0; i < LANES; i++) begin
            r = rows[LANES*b+i];
            in_slots[i] <= '{en: r.en, instr: r.instr, rs_val: r.rs, rt_val: r.rt};
        end
        exp_q.push_back(b);
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) stop_run("timed out waiting for out_valid");
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            in_slots[i] = '0;
        end
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);      // Quiet outputs before first bundle
        for (int b = 0; b < rows.size() / LANES; b++) begin
            send_bundle(b);             // Back to back
        end
        idle();
        wait_drain();
        send_bundle(0);                 // Both lost to the reset below
        send_bundle(5);
        @(posedge clk);
        in_valid <= 1'b0;
        rst_n    <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);
        send_bundle(8);
        idle();
        wait_drain();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: test/exec_cluster_asserts.sv
`timescale 1ns/1ps

module exec_cluster_asserts #(
    parameter int LANES = 4
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid,
    input logic                   out_valid,
    input mips_pkg::lane_res_t    out_res [LANES],
    input logic [$clog2(LANES):0] taken_count
);
    import mips_pkg::*;

    int               valid_n;          // Valid entries in output bundle
    logic [LANES-1:0] bad_taken;        // Illegal entry flagged taken

    always_comb begin
        valid_n = 0;
        for (int i = 0; i < LANES; i++) begin
            valid_n      = valid_n + int'(out_res[i].valid);
            bad_taken[i] = out_res[i].illegal & out_res[i].taken;
        end
    end

    // Three register stages between the strobes
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 3))
        else $error("out_valid not 3 cycles after in_valid");

    a_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    a_count: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> int'(taken_count) <= valid_n)
        else $error("taken_count exceeds the valid entries");

    a_illegal: assert property (@(posedge clk) disable iff (!rst_n) bad_taken == '0)
        else $error("illegal entry reported as taken");

endmodule

bind exec_cluster exec_cluster_asserts #(.LANES(LANES)) u_asserts (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
    .out_res(out_res), .taken_count(taken_count)
);

// File: logic/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster #(
    parameter int LANES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  mips_pkg::slot_t        in_slots [LANES],
    output logic                   out_valid,
    output mips_pkg::lane_res_t    out_res  [LANES],
    output logic [$clog2(LANES):0] taken_count,
    output logic                   any_illegal
);
    import mips_pkg::*;

    logic             disp_valid;       // Dispatch stage strobe
    slot_t            lane_slot [LANES];
    logic [LANES-1:0] res_valid;        // Lane stage strobes
    lane_res_t        lane_res  [LANES];

    bundle_dispatch #(.LANES(LANES)) u_dispatch (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_slots(in_slots),
        .disp_valid(disp_valid), .lane_slot(lane_slot)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        exec_lane u_lane (
            .clk(clk), .rst_n(rst_n), .disp_valid(disp_valid), .slot(lane_slot[i]),
            .res_valid(res_valid[i]), .res(lane_res[i])
        );
    end

    result_collect #(.LANES(LANES)) u_collect (
        .clk(clk), .rst_n(rst_n), .res_valid(res_valid), .lane_res(lane_res),
        .out_valid(out_valid), .out_res(out_res), .taken_count(taken_count),
        .any_illegal(any_illegal)
    );

endmodule

// File: logic/result_collect.sv
`timescale 1ns/1ps

module result_collect #(
    parameter int LANES = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [LANES-1:0]            res_valid,
    input  mips_pkg::lane_res_t         lane_res [LANES],
    output logic                        out_valid,
    output mips_pkg::lane_res_t         out_res  [LANES],
    output logic [$clog2(LANES):0]      taken_count,
    output logic                        any_illegal
);
    import mips_pkg::*;

    localparam int CW = $clog2(LANES) + 1; // Count width, holds LANES

    logic [CW-1:0] count_d;             // Taken entries this bundle
    logic          illegal_d;           // Some valid entry illegal

    always_comb begin
        count_d   = '0;
        illegal_d = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (lane_res[i].valid && lane_res[i].taken) begin
                count_d = count_d + CW'(1);
            end
            if (lane_res[i].valid && lane_res[i].illegal) begin
                illegal_d = 1'b1;
            end
        end
    end

    // Lanes run in lockstep so lane 0 stands for all
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            taken_count <= '0;
            any_illegal <= 1'b0;
            for (int i = 0; i < LANES; i++) begin
                out_res[i] <= '0;
            end
        end else begin
            out_valid <= res_valid[0];
            if (res_valid[0]) begin     // Hold last bundle between strobes
                taken_count <= count_d;
                any_illegal <= illegal_d;
                for (int i = 0; i < LANES; i++) begin
                    out_res[i] <= lane_res[i];
                end
            end
        end
    end

endmodule

// File: logic/bundle_dispatch.sv
`timescale 1ns/1ps

module bundle_dispatch #(
    parameter int LANES = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  mips_pkg::slot_t in_slots [LANES],
    output logic            disp_valid,
    output mips_pkg::slot_t lane_slot [LANES]
);
    import mips_pkg::*;

    logic [LANES-1:0] en_q;             // Slot enables, masked by in_valid
    logic [31:0]      instr_q [LANES];
    logic [XLEN-1:0]  rs_q    [LANES];
    logic [XLEN-1:0]  rt_q    [LANES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp_valid <= 1'b0;
            en_q       <= '0;
        end else begin
            disp_valid <= in_valid;
            for (int i = 0; i < LANES; i++) begin
                en_q[i] <= in_valid & in_slots[i].en; // Stale slots become bubbles
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            instr_q[i] <= in_slots[i].instr;
            rs_q[i]    <= in_slots[i].rs_val;
            rt_q[i]    <= in_slots[i].rt_val;
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_slot[i] = '{en: en_q[i], instr: instr_q[i], rs_val: rs_q[i], rt_val: rt_q[i]};
        end
    end

endmodule

// File: logic/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                disp_valid,
    input  mips_pkg::slot_t     slot,
    output logic                res_valid,
    output mips_pkg::lane_res_t res
);
    import mips_pkg::*;

    opcode_e         op;
    alu_op_e         alu_op;
    alu_ctrl_e       alu_ctrl;
    logic            use_imm, zero_ext, is_branch, is_jump;
    logic [XLEN-1:0] imm_ext;           // Extended immediate
    logic [XLEN-1:0] opnd_b;
    logic [XLEN-1:0] alu_y;
    logic            unsupported;
    logic            jr;                // Jump register
    logic            illegal;
    lane_res_t       res_d;

    assign op = opcode_e'(slot.instr[31:26]);
    assign imm_ext = zero_ext ? {16'h0000, slot.instr[15:0]}
                              : {{16{slot.instr[15]}}, slot.instr[15:0]};
    assign opnd_b = use_imm ? imm_ext : slot.rt_val;

    mips_main_dec u_main_dec (
        .op(op), .alu_op(alu_op), .use_imm(use_imm), .zero_ext(zero_ext),
        .is_branch(is_branch), .is_jump(is_jump)
    );

    mips_alu_dec u_alu_dec (
        .funct(slot.instr[5:0]), .op(slot.instr[31:26]), .dest(slot.instr[20:16]),
        .aluop(alu_op), .alucontrol(alu_ctrl)
    );

    mips_alu u_alu (
        .ctrl(alu_ctrl), .a(slot.rs_val), .b(opnd_b), .shamt(slot.instr[10:6]),
        .y(alu_y), .unsupported(unsupported)
    );

    assign jr      = ~is_jump & (alu_ctrl == ALU_PASS_A); // JR via funct
    assign illegal = (alu_op == ALUOP_NONE) | unsupported;

    always_comb begin
        res_d.valid   = slot.en;
        res_d.illegal = slot.en & illegal;
        res_d.result  = (slot.en & ~illegal) ? alu_y : '0; // Bubbles and illegal give 0
        res_d.taken   = slot.en & ~illegal & (is_jump | jr | (is_branch & alu_y[0]));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= disp_valid;    // One cycle behind dispatch
            res       <= res_d;
        end
    end

endmodule

// File: logic/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_ctrl_e ctrl,
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    input  logic [4:0]          shamt,
    output logic [31:0]         y,
    output logic                unsupported
);
    import mips_pkg::*;

    logic [XLEN-1:0] sum;               // a + b
    logic [XLEN-1:0] diff;              // a - b
    logic            lt_s;              // Signed a < b
    logic            lt_u;              // Unsigned a < b
    logic            a_neg;             // Sign of a
    logic            a_zero;            // a is all zeros
    logic [4:0]      var_sh;            // Variable shift amount

    assign sum    = a + b;
    assign diff   = a - b;
    assign lt_s   = $signed(a) < $signed(b);
    assign lt_u   = a < b;
    assign a_neg  = a[XLEN-1];
    assign a_zero = (a == '0);
    assign var_sh = a[4:0];             // Low bits of rs

    always_comb begin
        y           = '0;
        unsupported = 1'b0;
        case (ctrl)
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_ADDU:   y = sum;        // No overflow trap
            ALU_SUBU:   y = diff;
            ALU_SLT:    y = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   y = {{(XLEN-1){1'b0}}, lt_u};
            ALU_SLL:    y = b << shamt; // rt is the shifted value
            ALU_SRL:    y = b >> shamt;
            ALU_SRA:    y = $signed(b) >>> shamt;
            ALU_SLLV:   y = b << var_sh;
            ALU_SRLV:   y = b >> var_sh;
            ALU_SRAV:   y = $signed(b) >>> var_sh;
            ALU_EQ:     y = {{(XLEN-1){1'b0}}, (diff == '0)};
            ALU_NEZ:    y = {{(XLEN-1){1'b0}}, (diff != '0)};
            ALU_LTZ:    y = {{(XLEN-1){1'b0}}, a_neg};
            ALU_GEZ:    y = {{(XLEN-1){1'b0}}, ~a_neg};
            ALU_GTZ:    y = {{(XLEN-1){1'b0}}, ~a_neg & ~a_zero};
            ALU_LEZ:    y = {{(XLEN-1){1'b0}}, a_neg | a_zero};
            ALU_PASS_A: y = a;          // Jump result
            ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU: begin
                unsupported = 1'b1;     // No multiplier or divider
            end
            ALU_MTHI, ALU_MTLO: begin
                unsupported = 1'b1;     // No HI/LO registers
            end
            default: begin
                unsupported = 1'b1;     // ILLEGAL and unused codes
            end
        endcase
    end

endmodule

// File: logic/mips_alu_dec.sv
`timescale 1ns/1ps

module mips_alu_dec (
    input  logic [5:0]          funct,
    input  logic [5:0]          op,
    input  logic [4:0]          dest,
    input  mips_pkg::alu_op_e   aluop,
    output mips_pkg::alu_ctrl_e alucontrol
);
    import mips_pkg::*;

    always_comb begin
        case (aluop)
            ALUOP_ADD_MEM: alucontrol = ALU_ADDU;   // Address arithmetic
            ALUOP_JUMP:    alucontrol = ALU_PASS_A; // J and JAL forward rs
            ALUOP_DECODE: begin
                case (op)
                    OP_SPECIAL: begin
                        case (funct)
                            F_ADDU:  alucontrol = ALU_ADDU;
                            F_SUBU:  alucontrol = ALU_SUBU;
                            F_AND:   alucontrol = ALU_AND;
                            F_OR:    alucontrol = ALU_OR;
                            F_XOR:   alucontrol = ALU_XOR;
                            F_SLT:   alucontrol = ALU_SLT;
                            F_SLTU:  alucontrol = ALU_SLTU;
                            F_SLL:   alucontrol = ALU_SLL;  // Constant shifts
                            F_SRL:   alucontrol = ALU_SRL;
                            F_SRA:   alucontrol = ALU_SRA;
                            F_SLLV:  alucontrol = ALU_SLLV; // Amount from rs
                            F_SRLV:  alucontrol = ALU_SRLV;
                            F_SRAV:  alucontrol = ALU_SRAV;
                            F_MULT:  alucontrol = ALU_MULT; // Decoded, not executed
                            F_MULTU: alucontrol = ALU_MULTU;
                            F_DIV:   alucontrol = ALU_DIV;
                            F_DIVU:  alucontrol = ALU_DIVU;
                            F_MTHI:  alucontrol = ALU_MTHI;
                            F_MTLO:  alucontrol = ALU_MTLO;
                            F_JR:    alucontrol = ALU_PASS_A; // Jump register
                            default: alucontrol = ALU_ILLEGAL;
                        endcase
                    end
                    OP_REGIMM: begin
                        case (dest)
                            5'b00000: alucontrol = ALU_LTZ; // BLTZ
                            5'b00001: alucontrol = ALU_GEZ; // BGEZ
                            5'b10000: alucontrol = ALU_LTZ; // BLTZAL, no link here
                            5'b10001: alucontrol = ALU_GEZ; // BGEZAL
                            default:  alucontrol = ALU_ILLEGAL;
                        endcase
                    end
                    OP_BEQ:   alucontrol = ALU_EQ;
                    OP_BNE:   alucontrol = ALU_NEZ;
                    OP_BLEZ:  alucontrol = ALU_LEZ;
                    OP_BGTZ:  alucontrol = ALU_GTZ;
                    OP_ADDIU: alucontrol = ALU_ADDU;
                    OP_ANDI:  alucontrol = ALU_AND;
                    OP_ORI:   alucontrol = ALU_OR;
                    OP_XORI:  alucontrol = ALU_XOR;
                    OP_SLTI:  alucontrol = ALU_SLT;
                    OP_SLTIU: alucontrol = ALU_SLTU; // Unsigned compare, signed imm
                    default:  alucontrol = ALU_ILLEGAL;
                endcase
            end
            default: alucontrol = ALU_ILLEGAL; // NONE class
        endcase
    end

endmodule

// File: logic/mips_main_dec.sv
`timescale 1ns/1ps

module mips_main_dec (
    input  mips_pkg::opcode_e op,
    output mips_pkg::alu_op_e alu_op,
    output logic              use_imm,
    output logic              zero_ext,
    output logic              is_branch,
    output logic              is_jump
);
    import mips_pkg::*;

    always_comb begin
        alu_op    = ALUOP_NONE;         // Unknown unless listed
        use_imm   = 1'b0;
        zero_ext  = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (op)
            OP_SPECIAL: begin
                alu_op = ALUOP_DECODE;  // Funct picks the operation
            end
            OP_REGIMM: begin
                alu_op    = ALUOP_DECODE; // rt picks the test
                is_branch = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                alu_op    = ALUOP_DECODE; // Compare rs with rt
                is_branch = 1'b1;
            end
            OP_BLEZ, OP_BGTZ: begin
                alu_op    = ALUOP_DECODE; // Test rs alone
                is_branch = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                alu_op  = ALUOP_DECODE;
                use_imm = 1'b1;         // Sign-extended immediate
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_op   = ALUOP_DECODE;
                use_imm  = 1'b1;
                zero_ext = 1'b1;        // Logical ops zero-extend
            end
            OP_J, OP_JAL: begin
                alu_op  = ALUOP_JUMP;   // Result is rs_val
                is_jump = 1'b1;
            end
            default: begin
                alu_op = ALUOP_NONE;
            end
        endcase
    end

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    localparam int XLEN = 32;           // Datapath width

    // Primary opcodes handled by the cluster
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,         // R-type, see funct
        OP_REGIMM  = 6'b000001,         // Branch on sign, see rt
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110
    } opcode_e;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        F_SLL   = 6'b000000,
        F_SRL   = 6'b000010,
        F_SRA   = 6'b000011,
        F_SLLV  = 6'b000100,
        F_SRLV  = 6'b000110,
        F_SRAV  = 6'b000111,
        F_JR    = 6'b001000,
        F_MTHI  = 6'b010001,
        F_MTLO  = 6'b010011,
        F_MULT  = 6'b011000,
        F_MULTU = 6'b011001,
        F_DIV   = 6'b011010,
        F_DIVU  = 6'b011011,
        F_ADDU  = 6'b100001,
        F_SUBU  = 6'b100011,
        F_AND   = 6'b100100,
        F_OR    = 6'b100101,
        F_XOR   = 6'b100110,
        F_SLT   = 6'b101010,
        F_SLTU  = 6'b101011
    } funct_e;

    // Op class from the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD_MEM = 2'b00,          // Address add
        ALUOP_JUMP    = 2'b01,          // Pass source A
        ALUOP_DECODE  = 2'b10,          // Opcode and funct decide
        ALUOP_NONE    = 2'b11           // Not an instruction we know
    } alu_op_e;

    // ALU control codes
    typedef enum logic [4:0] {
        ALU_AND     = 5'd0,
        ALU_OR      = 5'd1,
        ALU_XOR     = 5'd2,
        ALU_ADDU    = 5'd3,
        ALU_SUBU    = 5'd4,
        ALU_SLTU    = 5'd5,
        ALU_SLT     = 5'd6,
        ALU_MULTU   = 5'd7,
        ALU_MULT    = 5'd8,
        ALU_SLL     = 5'd9,
        ALU_SLLV    = 5'd10,
        ALU_SRA     = 5'd11,
        ALU_SRL     = 5'd12,
        ALU_SRAV    = 5'd13,
        ALU_SRLV    = 5'd14,
        ALU_DIV     = 5'd15,
        ALU_DIVU    = 5'd16,
        ALU_MTHI    = 5'd17,
        ALU_MTLO    = 5'd18,
        ALU_LTZ     = 5'd19,            // a < 0
        ALU_GTZ     = 5'd20,            // a > 0
        ALU_GEZ     = 5'd21,            // a >= 0
        ALU_NEZ     = 5'd22,            // a - b nonzero, BNE
        ALU_LEZ     = 5'd23,            // a <= 0
        ALU_PASS_A  = 5'd24,            // Jumps
        ALU_EQ      = 5'd25,            // a - b zero, BEQ
        ALU_ILLEGAL = 5'd31
    } alu_ctrl_e;

    // One instruction slot of a bundle
    typedef struct packed {
        logic            en;            // Slot holds an instruction
        logic [31:0]     instr;
        logic [XLEN-1:0] rs_val;        // Source A as read
        logic [XLEN-1:0] rt_val;        // Source B as read
    } slot_t;

    // One lane result
    typedef struct packed {
        logic            valid;         // Copy of slot enable
        logic [XLEN-1:0] result;
        logic            taken;         // Branch or jump taken
        logic            illegal;       // Not executable here
    } lane_res_t;

endpackage
